// File: rtl/mm_settings.svh
/* matrix-multiply accelerator settings
   array size, element and accumulator widths, buffer addressing */
`ifndef MM_SETTINGS_SVH
`define MM_SETTINGS_SVH

// systolic array dimension, also matrix rows, columns and beats per row burst
`define MM_SA_WIDTH 4

// signed operand width
`define MM_ELEM_W 8

// accumulator width, holds 4 x (-128 x -128)
`define MM_ACC_W 20

// one row word per buffer entry
`define MM_BUF_AW 2

`endif

// File: rtl/mm_data_pkg.sv
/* data formats for the matrix-multiply accelerator
   operands, accumulators, bus words and byte addresses */
`include "mm_settings.svh"

package mm_data_pkg;

    // one matrix element
    typedef logic signed [`MM_ELEM_W-1:0] elem_t;

    // PE accumulator
    typedef logic signed [`MM_ACC_W-1:0] accum_t;

    // bus data word, one matrix row, element 0 in the low byte
    typedef logic [31:0] word_t;

    // byte address on the memory side
    typedef logic [31:0] addr_t;

endpackage

// File: rtl/mm_ctrl_pkg.sv
/* control encodings for the matrix-multiply accelerator
   DMA states and read transaction ids */
package mm_ctrl_pkg;

    // dma engine sequence
    typedef enum logic [2:0] {
        IDLE,
        ADDR_A,
        ADDR_B,
        LOAD,
        WAIT_MM,
        ADDR_C,
        WRITE_C,
        WAIT_B
    } dma_state_e;

    // read id, selects the destination buffer of an R beat
    typedef enum logic {ID_A = 1'b0, ID_B = 1'b1} rd_id_e;

endpackage

// File: rtl/mac_pe.sv
/* systolic processing element
   multiply-accumulate with registered east and south forwarding */
`timescale 1ns/1ps
`include "mm_settings.svh"

module mac_pe (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clear_i,
    input  mm_data_pkg::elem_t  a_i,
    input  mm_data_pkg::elem_t  b_i,
    output mm_data_pkg::elem_t  a_o,
    output mm_data_pkg::elem_t  b_o,
    output mm_data_pkg::accum_t acc_o
);
    import mm_data_pkg::*;

    elem_t  a_r;
    elem_t  b_r;
    accum_t acc_r;
    accum_t prod;

    // widen before the multiply so the signed product is kept whole
    assign prod = accum_t'(a_i) * accum_t'(b_i);

    always_ff @(posedge clk) begin
        if (!rst_n || clear_i) begin
            a_r   <= '0;
            b_r   <= '0;
            acc_r <= '0;
        end else begin
            a_r   <= a_i;
            b_r   <= b_i;
            acc_r <= acc_r + prod;
        end
    end

    assign a_o   = a_r;
    assign b_o   = b_r;
    assign acc_o = acc_r;

endmodule

// File: rtl/mm_feeder.sv
/* operand feeder for the systolic array
   holds row buffers A and B and drives skewed wavefronts into the edges */
`timescale 1ns/1ps
`include "mm_settings.svh"

module mm_feeder (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  buf_a_wren_i,
    input  logic [`MM_BUF_AW-1:0] buf_a_waddr_i,
    input  mm_data_pkg::word_t    buf_a_wdata_i,
    input  logic                  buf_b_wren_i,
    input  logic [`MM_BUF_AW-1:0] buf_b_waddr_i,
    input  mm_data_pkg::word_t    buf_b_wdata_i,
    input  logic                  mm_start_i,
    output logic                  clear_o,
    output mm_data_pkg::elem_t    a_west_o [`MM_SA_WIDTH],
    output mm_data_pkg::elem_t    b_north_o [`MM_SA_WIDTH],
    output logic                  mm_done_o
);
    import mm_data_pkg::*;

    localparam int SA        = `MM_SA_WIDTH;
    localparam int EW        = `MM_ELEM_W;
    localparam int STEP_W    = $clog2(3 * SA - 2);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(3 * SA - 3);

    // one row per word, element k in byte k
    word_t             buf_a [SA];
    word_t             buf_b [SA];
    logic [STEP_W-1:0] step;
    logic              busy;
    // one idle cycle so the last product lands before done
    logic              drain;

    always_ff @(posedge clk) begin
        if (buf_a_wren_i)
            buf_a[buf_a_waddr_i] <= buf_a_wdata_i;
        if (buf_b_wren_i)
            buf_b[buf_b_waddr_i] <= buf_b_wdata_i;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            step      <= '0;
            busy      <= 1'b0;
            drain     <= 1'b0;
            mm_done_o <= 1'b0;
        end else begin
            mm_done_o <= drain;
            drain     <= 1'b0;
            if (mm_start_i) begin
                step <= '0;
                busy <= 1'b1;
            end else if (busy) begin
                if (step == LAST_STEP) begin
                    busy  <= 1'b0;
                    drain <= 1'b1;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // PEs start clean with the run
    assign clear_o = mm_start_i;

    // row i sees A[i][t-i], column j sees B[t-j][j], zero outside the diagonal
    always_comb begin : wavefront
        int k;
        for (int i = 0; i < SA; i++) begin
            k            = int'(step) - i;
            a_west_o[i]  = '0;
            b_north_o[i] = '0;
            if (busy && k >= 0 && k < SA) begin
                a_west_o[i]  = buf_a[i][k*EW +: EW];
                b_north_o[i] = buf_b[k][i*EW +: EW];
            end
        end
    end

endmodule

// File: rtl/dma_engine.sv
/* DMA engine of the matrix-multiply accelerator
   reads A and B over AXI into the row buffers, starts the array,
   then streams the accumulators back to memory as one write burst */
`timescale 1ns/1ps
`include "mm_settings.svh"

module dma_engine (
    input  logic                         clk,
    input  logic                         rst_n,
    // configuration
    input  mm_data_pkg::addr_t           mat_a_addr_i,
    input  mm_data_pkg::addr_t           mat_b_addr_i,
    input  mm_data_pkg::addr_t           mat_c_addr_i,
    input  logic                         start_i,
    output logic                         done_o,
    // AR channel
    output logic                         arvalid_o,
    output mm_data_pkg::addr_t           araddr_o,
    output logic [7:0]                   arlen_o,
    output mm_ctrl_pkg::rd_id_e          arid_o,
    input  logic                         arready_i,
    // R channel
    input  logic                         rvalid_i,
    input  mm_data_pkg::word_t           rdata_i,
    input  mm_ctrl_pkg::rd_id_e          rid_i,
    input  logic                         rlast_i,
    output logic                         rready_o,
    // AW channel
    output logic                         awvalid_o,
    output mm_data_pkg::addr_t           awaddr_o,
    output logic [7:0]                   awlen_o,
    input  logic                         awready_i,
    // W channel
    output logic                         wvalid_o,
    output mm_data_pkg::word_t           wdata_o,
    output logic                         wlast_o,
    input  logic                         wready_i,
    // B channel
    input  logic                         bvalid_i,
    output logic                         bready_o,
    // row buffer writes
    output logic                         buf_a_wren_o,
    output logic [`MM_BUF_AW-1:0]        buf_a_waddr_o,
    output mm_data_pkg::word_t           buf_a_wdata_o,
    output logic                         buf_b_wren_o,
    output logic [`MM_BUF_AW-1:0]        buf_b_waddr_o,
    output mm_data_pkg::word_t           buf_b_wdata_o,
    // array control
    output logic                         mm_start_o,
    input  logic                         mm_done_i,
    input  mm_data_pkg::accum_t          accum_i [`MM_SA_WIDTH][`MM_SA_WIDTH]
);
    import mm_data_pkg::*;
    import mm_ctrl_pkg::*;

    localparam int AW = `MM_BUF_AW;
    localparam logic [7:0] RD_LEN = 8'(`MM_SA_WIDTH - 1);
    localparam logic [7:0] WR_LEN = 8'(`MM_SA_WIDTH * `MM_SA_WIDTH - 1);
    localparam logic [2*AW-1:0] LAST_C = (2*AW)'(`MM_SA_WIDTH * `MM_SA_WIDTH - 1);

    dma_state_e      state;
    dma_state_e      state_nx;
    addr_t           addr_a_r;
    addr_t           addr_b_r;
    addr_t           addr_c_r;
    // per-id beat counters double as buffer addresses
    logic [AW-1:0]   cnt_a;
    logic [AW-1:0]   cnt_b;
    logic            last_a;
    logic            last_b;
    // C beat counter, upper half row, lower half column
    logic [2*AW-1:0] cnt_c;
    logic            r_hs;
    logic            w_hs;
    logic            load_done;
    logic            run_start;
    accum_t          cur_acc;

    assign r_hs      = rvalid_i && rready_o;
    assign w_hs      = wvalid_o && wready_i;
    assign load_done = last_a && last_b;
    assign run_start = (state == IDLE) && start_i;

    // read requests, A first then B
    assign arvalid_o = (state == ADDR_A) || (state == ADDR_B);
    assign araddr_o  = (state == ADDR_B) ? addr_b_r : addr_a_r;
    assign arid_o    = (state == ADDR_B) ? ID_B : ID_A;
    assign arlen_o   = RD_LEN;
    assign rready_o  = (state == LOAD) && !load_done;

    // write burst of C
    assign awvalid_o = (state == ADDR_C);
    assign awaddr_o  = addr_c_r;
    assign awlen_o   = WR_LEN;
    assign wvalid_o  = (state == WRITE_C);
    assign wlast_o   = wvalid_o && (cnt_c == LAST_C);
    assign bready_o  = (state == WAIT_B);

    // row-major pick, sign-extended to the bus word
    assign cur_acc = accum_i[cnt_c[2*AW-1:AW]][cnt_c[AW-1:0]];
    assign wdata_o = {{(32-`MM_ACC_W){cur_acc[`MM_ACC_W-1]}}, cur_acc};

    always_comb begin
        state_nx = state;
        case (state)
            IDLE:
                if (start_i)
                    state_nx = ADDR_A;
            ADDR_A:
                if (arready_i)
                    state_nx = ADDR_B;
            ADDR_B:
                if (arready_i)
                    state_nx = LOAD;
            // both ids may interleave, leave once each has seen rlast
            LOAD:
                if (load_done)
                    state_nx = WAIT_MM;
            WAIT_MM:
                if (mm_done_i)
                    state_nx = ADDR_C;
            ADDR_C:
                if (awready_i)
                    state_nx = WRITE_C;
            WRITE_C:
                if (w_hs && wlast_o)
                    state_nx = WAIT_B;
            WAIT_B:
                if (bvalid_i)
                    state_nx = IDLE;
            default:
                state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= IDLE;
            cnt_a        <= '0;
            cnt_b        <= '0;
            last_a       <= 1'b0;
            last_b       <= 1'b0;
            cnt_c        <= '0;
            buf_a_wren_o <= 1'b0;
            buf_b_wren_o <= 1'b0;
            mm_start_o   <= 1'b0;
            done_o       <= 1'b0;
        end else begin
            state        <= state_nx;
            buf_a_wren_o <= 1'b0;
            buf_b_wren_o <= 1'b0;
            // single-cycle pulses tied to state exits
            mm_start_o   <= (state == LOAD) && load_done;
            done_o       <= (state == WAIT_B) && bvalid_i;
            if (run_start) begin
                cnt_a  <= '0;
                cnt_b  <= '0;
                last_a <= 1'b0;
                last_b <= 1'b0;
                cnt_c  <= '0;
            end
            // steer each R beat by id
            if (r_hs && rid_i == ID_A) begin
                buf_a_wren_o <= 1'b1;
                cnt_a        <= cnt_a + 1'b1;
                if (rlast_i)
                    last_a <= 1'b1;
            end
            if (r_hs && rid_i == ID_B) begin
                buf_b_wren_o <= 1'b1;
                cnt_b        <= cnt_b + 1'b1;
                if (rlast_i)
                    last_b <= 1'b1;
            end
            if (w_hs)
                cnt_c <= cnt_c + 1'b1;
        end
    end

    // base addresses held for the whole run
    always_ff @(posedge clk) begin
        if (run_start) begin
            addr_a_r <= mat_a_addr_i;
            addr_b_r <= mat_b_addr_i;
            addr_c_r <= mat_c_addr_i;
        end
        if (r_hs && rid_i == ID_A) begin
            buf_a_waddr_o <= cnt_a;
            buf_a_wdata_o <= rdata_i;
        end
        if (r_hs && rid_i == ID_B) begin
            buf_b_waddr_o <= cnt_b;
            buf_b_wdata_o <= rdata_i;
        end
    end

endmodule

// File: rtl/mm_accel_top.sv
/* matrix-multiply accelerator top
   DMA engine, operand feeder and the PE grid */
`timescale 1ns/1ps
`include "mm_settings.svh"

module mm_accel_top (
    input  logic                clk,
    input  logic                rst_n,
    input  mm_data_pkg::addr_t  mat_a_addr_i,
    input  mm_data_pkg::addr_t  mat_b_addr_i,
    input  mm_data_pkg::addr_t  mat_c_addr_i,
    input  logic                start_i,
    output logic                done_o,
    output logic                arvalid_o,
    output mm_data_pkg::addr_t  araddr_o,
    output logic [7:0]          arlen_o,
    output mm_ctrl_pkg::rd_id_e arid_o,
    input  logic                arready_i,
    input  logic                rvalid_i,
    input  mm_data_pkg::word_t  rdata_i,
    input  mm_ctrl_pkg::rd_id_e rid_i,
    input  logic                rlast_i,
    output logic                rready_o,
    output logic                awvalid_o,
    output mm_data_pkg::addr_t  awaddr_o,
    output logic [7:0]          awlen_o,
    input  logic                awready_i,
    output logic                wvalid_o,
    output mm_data_pkg::word_t  wdata_o,
    output logic                wlast_o,
    input  logic                wready_i,
    input  logic                bvalid_i,
    output logic                bready_o
);
    import mm_data_pkg::*;

    localparam int SA = `MM_SA_WIDTH;

    logic                  buf_a_wren;
    logic                  buf_b_wren;
    logic [`MM_BUF_AW-1:0] buf_a_waddr;
    logic [`MM_BUF_AW-1:0] buf_b_waddr;
    word_t                 buf_a_wdata;
    word_t                 buf_b_wdata;
    logic                  mm_start;
    logic                  mm_done;
    logic                  clear;
    elem_t                 a_west [SA];
    elem_t                 b_north [SA];
    // horizontal links, column SA is the unused east edge
    elem_t                 a_h [SA][SA+1];
    // vertical links, row SA is the unused south edge
    elem_t                 b_v [SA+1][SA];
    accum_t                accum [SA][SA];

    dma_engine u_dma (
        .clk           (clk),
        .rst_n         (rst_n),
        .mat_a_addr_i  (mat_a_addr_i),
        .mat_b_addr_i  (mat_b_addr_i),
        .mat_c_addr_i  (mat_c_addr_i),
        .start_i       (start_i),
        .done_o        (done_o),
        .arvalid_o     (arvalid_o),
        .araddr_o      (araddr_o),
        .arlen_o       (arlen_o),
        .arid_o        (arid_o),
        .arready_i     (arready_i),
        .rvalid_i      (rvalid_i),
        .rdata_i       (rdata_i),
        .rid_i         (rid_i),
        .rlast_i       (rlast_i),
        .rready_o      (rready_o),
        .awvalid_o     (awvalid_o),
        .awaddr_o      (awaddr_o),
        .awlen_o       (awlen_o),
        .awready_i     (awready_i),
        .wvalid_o      (wvalid_o),
        .wdata_o       (wdata_o),
        .wlast_o       (wlast_o),
        .wready_i      (wready_i),
        .bvalid_i      (bvalid_i),
        .bready_o      (bready_o),
        .buf_a_wren_o  (buf_a_wren),
        .buf_a_waddr_o (buf_a_waddr),
        .buf_a_wdata_o (buf_a_wdata),
        .buf_b_wren_o  (buf_b_wren),
        .buf_b_waddr_o (buf_b_waddr),
        .buf_b_wdata_o (buf_b_wdata),
        .mm_start_o    (mm_start),
        .mm_done_i     (mm_done),
        .accum_i       (accum)
    );

    mm_feeder u_feeder (
        .clk           (clk),
        .rst_n         (rst_n),
        .buf_a_wren_i  (buf_a_wren),
        .buf_a_waddr_i (buf_a_waddr),
        .buf_a_wdata_i (buf_a_wdata),
        .buf_b_wren_i  (buf_b_wren),
        .buf_b_waddr_i (buf_b_waddr),
        .buf_b_wdata_i (buf_b_wdata),
        .mm_start_i    (mm_start),
        .clear_o       (clear),
        .a_west_o      (a_west),
        .b_north_o     (b_north),
        .mm_done_o     (mm_done)
    );

    // PE(i,j) takes a from the west and b from the north
    for (genvar i = 0; i < SA; i++) begin : g_row
        assign a_h[i][0] = a_west[i];
        assign b_v[0][i] = b_north[i];
        for (genvar j = 0; j < SA; j++) begin : g_col
            mac_pe u_pe (
                .clk     (clk),
                .rst_n   (rst_n),
                .clear_i (clear),
                .a_i     (a_h[i][j]),
                .b_i     (b_v[i][j]),
                .a_o     (a_h[i][j+1]),
                .b_o     (b_v[i+1][j]),
                .acc_o   (accum[i][j])
            );
        end
    end

endmodule

// File: bench/mm_accel_props.sv
/* channel properties of the DMA engine
   payload stability, wlast position, start pulse, done vs write data */
`timescale 1ns/1ps
`include "mm_settings.svh"

module mm_accel_props (
    input logic                clk,
    input logic                rst_n,
    input logic                arvalid_i,
    input logic                arready_i,
    input mm_data_pkg::addr_t  araddr_i,
    input logic [7:0]          arlen_i,
    input mm_ctrl_pkg::rd_id_e arid_i,
    input logic                awvalid_i,
    input logic                awready_i,
    input mm_data_pkg::addr_t  awaddr_i,
    input logic [7:0]          awlen_i,
    input logic                wvalid_i,
    input logic                wready_i,
    input mm_data_pkg::word_t  wdata_i,
    input logic                wlast_i,
    input logic                mm_start_i,
    input logic                done_i
);
    import mm_data_pkg::*;

    localparam logic [7:0] LAST_BEAT = 8'(`MM_SA_WIDTH * `MM_SA_WIDTH - 1);

    int unsigned fail_count = 0;
    logic [7:0]  w_beat;

    // W beats since the last AW handshake
    always_ff @(posedge clk) begin
        if (!rst_n || (awvalid_i && awready_i))
            w_beat <= '0;
        else if (wvalid_i && wready_i)
            w_beat <= w_beat + 1'b1;
    end

    ar_held: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i)
                                    && $stable(arid_i) && $stable(arlen_i))
        else begin fail_count++; $error("AR payload moved before its handshake"); end

    aw_held: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i) && $stable(awlen_i))
        else begin fail_count++; $error("AW payload moved before its handshake"); end

    w_held: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wlast_i))
        else begin fail_count++; $error("W payload moved before its handshake"); end

    // wlast on beat 16 and nowhere else
    wlast_pos: assert property (@(posedge clk) disable iff (!rst_n)
        wvalid_i |-> (wlast_i == (w_beat == LAST_BEAT)))
        else begin fail_count++; $error("wlast on the wrong beat"); end

    start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mm_start_i |=> !mm_start_i)
        else begin fail_count++; $error("mm_start longer than one cycle"); end

    done_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done_i) |-> !wvalid_i)
        else begin fail_count++; $error("done raised during the write burst"); end

endmodule

bind dma_engine mm_accel_props u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .arvalid_i  (arvalid_o),
    .arready_i  (arready_i),
    .araddr_i   (araddr_o),
    .arlen_i    (arlen_o),
    .arid_i     (arid_o),
    .awvalid_i  (awvalid_o),
    .awready_i  (awready_i),
    .awaddr_i   (awaddr_o),
    .awlen_i    (awlen_o),
    .wvalid_i   (wvalid_o),
    .wready_i   (wready_i),
    .wdata_i    (wdata_o),
    .wlast_i    (wlast_o),
    .mm_start_i (mm_start_o),
    .done_i     (done_o)
);

// File: bench/mm_accel_tb.sv
/* testbench for the matrix-multiply accelerator
   memory model with random stalls, table of cases and a reference product */
`timescale 1ns/1ps
`include "mm_settings.svh"

module mm_accel_tb;
    import mm_data_pkg::*;
    import mm_ctrl_pkg::*;

    localparam int SA        = `MM_SA_WIDTH;
    localparam int EW        = `MM_ELEM_W;
    localparam int MEM_WORDS = 64;
    localparam int N_CASES   = 4;
    localparam int RUN_LIMIT = 2000;

    // DUT inputs, all start low
    logic   clk     = 1'b0;
    logic   rst_n   = 1'b0;
    addr_t  a_addr  = '0;
    addr_t  b_addr  = '0;
    addr_t  c_addr  = '0;
    logic   start   = 1'b0;
    logic   arready = 1'b0;
    logic   rvalid  = 1'b0;
    word_t  rdata   = '0;
    rd_id_e rid     = ID_A;
    logic   rlast   = 1'b0;
    logic   awready = 1'b0;
    logic   wready  = 1'b0;
    logic   bvalid  = 1'b0;

    // DUT outputs
    logic       done;
    logic       arvalid;
    addr_t      araddr;
    logic [7:0] arlen;
    rd_id_e     arid;
    logic       rready;
    logic       awvalid;
    addr_t      awaddr;
    logic [7:0] awlen;
    logic       wvalid;
    word_t      wdata;
    logic       wlast;
    logic       bready;

    // case table: row words of A and B, base addresses A, B, C, stall flag
    word_t tab_a     [N_CASES][SA];
    word_t tab_b     [N_CASES][SA];
    addr_t tab_addr  [N_CASES][3];
    logic  tab_stall [N_CASES];
    int    exp_c     [N_CASES][SA][SA];

    // memory model state
    word_t       mem [MEM_WORDS];
    logic [31:0] seed = 32'h69b5_2a9f;
    logic        stall_on = 1'b0;
    addr_t       rd_base_q [$];
    rd_id_e      rd_id_q [$];
    addr_t       ar_seen_addr [$];
    rd_id_e      ar_seen_id [$];
    int          rd_beat = 0;
    int          wr_beat = 0;
    addr_t       wr_base = '0;
    logic        b_due = 1'b0;
    int          done_total = 0;
    // transfers agreed at a falling edge, completed at the next rising edge
    logic        ar_go = 1'b0;
    logic        r_go  = 1'b0;
    logic        aw_go = 1'b0;
    logic        w_go  = 1'b0;
    logic        b_go  = 1'b0;
    addr_t       ar_addr_s;
    rd_id_e      ar_id_s;
    logic [7:0]  ar_len_s;
    addr_t       aw_addr_s;
    logic [7:0]  aw_len_s;
    word_t       w_data_s;
    logic        w_last_s;

    mm_accel_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .mat_a_addr_i (a_addr),
        .mat_b_addr_i (b_addr),
        .mat_c_addr_i (c_addr),
        .start_i      (start),
        .done_o       (done),
        .arvalid_o    (arvalid),
        .araddr_o     (araddr),
        .arlen_o      (arlen),
        .arid_o       (arid),
        .arready_i    (arready),
        .rvalid_i     (rvalid),
        .rdata_i      (rdata),
        .rid_i        (rid),
        .rlast_i      (rlast),
        .rready_o     (rready),
        .awvalid_o    (awvalid),
        .awaddr_o     (awaddr),
        .awlen_o      (awlen),
        .awready_i    (awready),
        .wvalid_o     (wvalid),
        .wdata_o      (wdata),
        .wlast_o      (wlast),
        .wready_i     (wready),
        .bvalid_i     (bvalid),
        .bready_o     (bready)
    );

    always #10 clk = ~clk;

    task automatic report_failure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            report_failure($sformatf("Error at %0t ns: %s = 0x%08h, expected 0x%08h",
                                     $time, name, got, exp));
    endtask

    task automatic check_accum(input string name, input accum_t got, input accum_t exp);
        if (got !== exp)
            report_failure($sformatf("Error at %0t ns: %s = %0d, expected %0d",
                                     $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("Error at %0t ns: %s = %b, expected %b",
                                     $time, name, got, exp));
    endtask

    // LCG step, one random bit per call
    function automatic logic coin();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed[24];
    endfunction

    // word slot of a byte address plus beat, wraps inside the model
    function automatic logic [5:0] word_index(input addr_t a, input int beat);
        return a[7:2] + 6'(beat);
    endfunction

    // plain integer product of signed elements
    function automatic void compute_reference(input int k);
        int sum;
        for (int i = 0; i < SA; i++) begin
            for (int j = 0; j < SA; j++) begin
                sum = 0;
                for (int m = 0; m < SA; m++)
                    sum += int'($signed(tab_a[k][i][m*EW +: EW]))
                         * int'($signed(tab_b[k][m][j*EW +: EW]));
                exp_c[k][i][j] = sum;
            end
        end
    endfunction

    task automatic fill_table();
        // identity A, so C must equal B
        tab_a[0] = '{32'h0000_0001, 32'h0000_0100, 32'h0001_0000, 32'h0100_0000};
        tab_b[0] = '{32'h807f_ff01, 32'h1234_56f0, 32'hfe02_9c64, 32'h0a0b_c0d0};
        // all -128, every sum reaches 65536
        tab_a[1] = '{32'h8080_8080, 32'h8080_8080, 32'h8080_8080, 32'h8080_8080};
        tab_b[1] = '{32'h8080_8080, 32'h8080_8080, 32'h8080_8080, 32'h8080_8080};
        // mixed signs, stalls on
        tab_a[2] = '{32'h7f80_01ff, 32'h05fb_0af6, 32'h8101_7e02, 32'hff7f_0080};
        tab_b[2] = '{32'h03fd_7f81, 32'h80ff_0102, 32'h1ee2_40c0, 32'h7f7f_8080};
        tab_a[3] = '{32'h0102_0304, 32'hf0e0_d0c0, 32'h2a55_aa80, 32'h0011_ee99};
        tab_b[3] = '{32'hffff_ffff, 32'h0101_0101, 32'h807f_807f, 32'h1357_9bdf};
        // C regions at 0x40, 0x80, 0xc0 never overlap A or B
        tab_addr[0] = '{32'h00, 32'h10, 32'h40};
        tab_addr[1] = '{32'h20, 32'h30, 32'h80};
        tab_addr[2] = '{32'h10, 32'h00, 32'hc0};
        tab_addr[3] = '{32'h20, 32'h30, 32'h40};
        tab_stall = '{1'b0, 1'b0, 1'b1, 1'b1};
    endtask

    always @(negedge clk) begin : memory_model
        if (!rst_n) begin
            arready = 1'b0;
            rvalid  = 1'b0;
            awready = 1'b0;
            wready  = 1'b0;
            bvalid  = 1'b0;
            ar_go   = 1'b0;
            r_go    = 1'b0;
            aw_go   = 1'b0;
            w_go    = 1'b0;
            b_go    = 1'b0;
        end else begin
            if (ar_go) begin
                rd_base_q.push_back(ar_addr_s);
                rd_id_q.push_back(ar_id_s);
                ar_seen_addr.push_back(ar_addr_s);
                ar_seen_id.push_back(ar_id_s);
                check_word("arlen_o", word_t'(ar_len_s), word_t'(SA - 1));
            end
            if (r_go) begin
                rvalid = 1'b0;
                if (rd_beat == SA - 1) begin
                    rd_base_q.pop_front();
                    rd_id_q.pop_front();
                    rd_beat = 0;
                end else begin
                    rd_beat++;
                end
            end
            if (aw_go) begin
                wr_base = aw_addr_s;
                wr_beat = 0;
                check_word("awlen_o", word_t'(aw_len_s), word_t'(SA * SA - 1));
            end
            if (w_go) begin
                mem[word_index(wr_base, wr_beat)] = w_data_s;
                check_flag("wlast_o", w_last_s, wr_beat == SA * SA - 1);
                wr_beat++;
                if (w_last_s)
                    b_due = 1'b1;
            end
            if (b_go)
                bvalid = 1'b0;
            // coin drawn every cycle so the sequence does not hang on stall_on
            arready = coin() || !stall_on;
            awready = coin() || !stall_on;
            wready  = coin() || !stall_on;
            if (!rvalid && rd_base_q.size() > 0 && (coin() || !stall_on)) begin
                rvalid = 1'b1;
                rdata  = mem[word_index(rd_base_q[0], rd_beat)];
                rid    = rd_id_q[0];
                rlast  = (rd_beat == SA - 1);
            end
            if (b_due && !bvalid && (coin() || !stall_on)) begin
                bvalid = 1'b1;
                b_due  = 1'b0;
            end
            // DUT side is stable until the next rising edge
            ar_go     = arvalid && arready;
            ar_addr_s = araddr;
            ar_id_s   = arid;
            ar_len_s  = arlen;
            r_go      = rvalid && rready;
            aw_go     = awvalid && awready;
            aw_addr_s = awaddr;
            aw_len_s  = awlen;
            w_go      = wvalid && wready;
            w_data_s  = wdata;
            w_last_s  = wlast;
            b_go      = bvalid && bready;
        end
    end

    always @(negedge clk) begin : monitors
        if (rst_n && done)
            done_total++;
        if (u_dut.u_dma.u_props.fail_count != 0)
            report_failure("a DMA channel assertion failed");
    end

    task automatic compare_region(input int k);
        word_t got;
        int    exp;
        string name;
        for (int n = 0; n < SA * SA; n++) begin
            got  = mem[word_index(tab_addr[k][2], n)];
            exp  = exp_c[k][n / SA][n % SA];
            name = $sformatf("C[%0d][%0d] of case %0d", n / SA, n % SA, k);
            // accumulator value first, then the sign extension of the bus word
            check_accum(name, accum_t'(got), accum_t'(exp));
            check_word(name, got, word_t'(exp));
        end
    endtask

    task automatic run_case(input int c);
        int cycles;
        compute_reference(c);
        for (int r = 0; r < SA; r++) begin
            mem[word_index(tab_addr[c][0], r)] = tab_a[c][r];
            mem[word_index(tab_addr[c][1], r)] = tab_b[c][r];
        end
        ar_seen_addr.delete();
        ar_seen_id.delete();
        stall_on = tab_stall[c];
        a_addr   = tab_addr[c][0];
        b_addr   = tab_addr[c][1];
        c_addr   = tab_addr[c][2];
        start    = 1'b1;
        @(negedge clk);
        start  = 1'b0;
        cycles = 0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles > RUN_LIMIT)
                report_failure($sformatf("timeout: case %0d never raised done_o", c));
        end
        @(negedge clk);
        check_flag("done_o", done, 1'b0);
        check_word("done_o pulse count", word_t'(done_total), word_t'(c + 1));
        // A first, then B, one burst each
        check_word("AR request count", word_t'(ar_seen_addr.size()), word_t'(2));
        check_word("araddr of burst 0", ar_seen_addr[0], tab_addr[c][0]);
        check_word("arid of burst 0", word_t'(ar_seen_id[0]), word_t'(ID_A));
        check_word("araddr of burst 1", ar_seen_addr[1], tab_addr[c][1]);
        check_word("arid of burst 1", word_t'(ar_seen_id[1]), word_t'(ID_B));
        compare_region(c);
        // the previous run's C stays as it was
        if (c > 0)
            compare_region(c - 1);
    endtask

    initial begin : stimulus
        for (int w = 0; w < MEM_WORDS; w++)
            mem[w] = 32'h5ee0_0000 | word_t'(w);
        fill_table();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_flag("done_o", done, 1'b0);
        check_flag("arvalid_o", arvalid, 1'b0);
        check_flag("awvalid_o", awvalid, 1'b0);
        check_flag("wvalid_o", wvalid, 1'b0);
        check_flag("rready_o", rready, 1'b0);
        check_flag("bready_o", bready, 1'b0);
        // idle without start
        for (int n = 0; n < 20; n++) begin
            @(negedge clk);
            check_flag("arvalid_o", arvalid, 1'b0);
            check_flag("awvalid_o", awvalid, 1'b0);
        end
        for (int c = 0; c < N_CASES; c++)
            run_case(c);
        if (u_dut.u_dma.u_props.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            report_failure("a DMA channel assertion failed");
        end
    end

endmodule

// File: build.f
+incdir+rtl
rtl/mm_data_pkg.sv
rtl/mm_ctrl_pkg.sv
rtl/mac_pe.sv
rtl/mm_feeder.sv
rtl/dma_engine.sv
rtl/mm_accel_top.sv
bench/mm_accel_props.sv
bench/mm_accel_tb.sv

// File: Makefile
# Verilator flow for the matrix-multiply accelerator testbench

TOP := mm_accel_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

# the run passes only if the log holds the pass line
test:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
